// ==== files.f ====
+incdir+include
hw/pe_pkg.sv
hw/pe_pipe_reg.sv
hw/pe_decode.sv
hw/fp_add_sub.sv
hw/fp_mul.sv
hw/pe_result.sv
hw/pe_top.sv
testbench/pe_chk.sv
testbench/pe_scoreboard.sv
testbench/pe_tb.sv

// ==== hw/fp_add_sub.sv ====
`timescale 1ns/1ns
`include "pe_defs.svh"

// aligned add/subtract, truncating, pure logic
module fp_add_sub (
  input  pe_pkg::pe_dec_t       beat,
  output logic [`PE_DATA_W-1:0] sum
);

  localparam int SIG_W   = `PE_MAN_W + 1;         // with hidden bit
  localparam int EXT_W   = SIG_W + 3;             // guard, round, sticky below
  localparam int EXP_MAX = (1 << `PE_EXP_W) - 1;  // all ones is infinity

  pe_pkg::pe_unpacked_t    op_a;
  pe_pkg::pe_unpacked_t    op_b;
  pe_pkg::pe_unpacked_t    big;   // larger magnitude
  pe_pkg::pe_unpacked_t    sml;
  logic                    eff_sub;
  logic                    a_leads;
  logic [`PE_EXP_W-1:0]    exp_diff;
  logic [EXT_W-1:0]        big_ext;
  logic [EXT_W-1:0]        sml_ext;
  logic [EXT_W-1:0]        sml_aln;
  logic [EXT_W-1:0]        drop_mask; // bits lost by the shift
  logic [EXT_W:0]          raw;       // one carry bit on top
  logic [EXT_W:0]          norm;
  logic [5:0]              lz;
  logic signed [`PE_EXP_W+1:0] exp_r;

  function automatic logic [`PE_DATA_W-1:0] pack(input pe_pkg::pe_unpacked_t u);
    return {u.sign, u.exp, u.sig[`PE_MAN_W-1:0]};
  endfunction

  always_comb begin
    ////////////////////////////////////////
    // sign fix and swap
    ////////////////////////////////////////
    op_a      = beat.a;
    op_b      = beat.b;
    op_b.sign = beat.b.sign ^ (beat.op == pe_pkg::OP_SUB); // a - b is a + (-b)
    eff_sub   = op_a.sign ^ op_b.sign;
    a_leads   = {op_a.exp, op_a.sig} >= {op_b.exp, op_b.sig};
    big       = a_leads ? op_a : op_b;
    sml       = a_leads ? op_b : op_a;

    // alignment
    exp_diff = big.exp - sml.exp;
    big_ext  = {big.sig, 3'b000};
    sml_ext  = {sml.sig, 3'b000};
    if (exp_diff >= EXT_W) begin
      sml_aln   = '0; // shifted fully out
      drop_mask = '1;
    end else begin
      sml_aln   = sml_ext >> exp_diff;
      drop_mask = ~({EXT_W{1'b1}} << exp_diff);
    end
    sml_aln[0] = sml_aln[0] | (|(sml_ext & drop_mask)); // sticky keeps truncation exact

    // magnitude add or subtract, big leads so no borrow out
    if (eff_sub) raw = {1'b0, big_ext} - {1'b0, sml_aln};
    else         raw = {1'b0, big_ext} + {1'b0, sml_aln};

    ////////////////////////////////////////
    // normalize
    ////////////////////////////////////////
    lz = '0;
    for (int i = 0; i <= EXT_W; i++) begin
      if (raw[i]) lz = 6'(EXT_W - i); // last hit is the leading one
    end
    norm  = raw << lz; // leading one lands on the carry bit
    exp_r = $signed({2'b00, big.exp}) + 13'sd1 - $signed({7'b0, lz});

    // repack, special cases first
    if (op_a.is_zero && op_b.is_zero) begin
      sum = {op_a.sign & op_b.sign, {(`PE_DATA_W-1){1'b0}}}; // -0 only from -0 + -0
    end else if (op_b.is_zero) begin
      sum = pack(op_a);
    end else if (op_a.is_zero) begin
      sum = pack(op_b); // sign already flipped for sub
    end else if (raw == '0) begin
      sum = '0; // exact cancellation is +0
    end else if (exp_r >= EXP_MAX) begin
      sum = {big.sign, {`PE_EXP_W{1'b1}}, {`PE_MAN_W{1'b0}}}; // signed infinity
    end else if (exp_r <= 0) begin
      sum = {big.sign, {(`PE_DATA_W-1){1'b0}}}; // flush to signed zero
    end else begin
      sum = {big.sign, exp_r[`PE_EXP_W-1:0], norm[EXT_W-1 -: `PE_MAN_W]}; // truncate
    end
  end

endmodule

// ==== hw/fp_mul.sv ====
`timescale 1ns/1ns
`include "pe_defs.svh"

// significand multiply, truncating, pure logic
module fp_mul (
  input  pe_pkg::pe_dec_t       beat,
  output logic [`PE_DATA_W-1:0] product
);

  localparam int SIG_W   = `PE_MAN_W + 1;
  localparam int BIAS    = `PE_EXP_BIAS;
  localparam int EXP_MAX = (1 << `PE_EXP_W) - 1;

  logic                        sign;
  logic [2*SIG_W-1:0]          prod;  // 1.x * 1.x lies in [1, 4)
  logic                        carry; // product reached 2.0
  logic signed [`PE_EXP_W+1:0] exp_r;
  logic [`PE_MAN_W-1:0]        frac;

  assign sign  = beat.a.sign ^ beat.b.sign;
  assign prod  = beat.a.sig * beat.b.sig;
  assign carry = prod[2*SIG_W-1];

  // exponents add, one bias comes off
  assign exp_r = $signed({2'b00, beat.a.exp}) + $signed({2'b00, beat.b.exp})
               - 13'(BIAS) + $signed({12'b0, carry});

  // one-bit normalize, low bits dropped
  assign frac = carry ? prod[2*SIG_W-2 -: `PE_MAN_W]
                      : prod[2*SIG_W-3 -: `PE_MAN_W];

  always_comb begin
    if (beat.a.is_zero || beat.b.is_zero) begin
      product = {sign, {(`PE_DATA_W-1){1'b0}}}; // signed zero
    end else if (exp_r >= EXP_MAX) begin
      product = {sign, {`PE_EXP_W{1'b1}}, {`PE_MAN_W{1'b0}}}; // overflow
    end else if (exp_r <= 0) begin
      product = {sign, {(`PE_DATA_W-1){1'b0}}}; // below smallest normal
    end else begin
      product = {sign, exp_r[`PE_EXP_W-1:0], frac};
    end
  end

endmodule

// ==== hw/pe_decode.sv ====
`timescale 1ns/1ns
`include "pe_defs.svh"

module pe_decode (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [`PE_DATA_W-1:0] in_a,
  input  logic [`PE_DATA_W-1:0] in_b,
  input  pe_pkg::pe_op_e        in_op,
  output logic                  dec_valid,
  input  logic                  dec_ready,
  output pe_pkg::pe_dec_t       dec_beat
);

  ////////////////////////////////////////
  // operand unpack
  ////////////////////////////////////////

  function automatic pe_pkg::pe_unpacked_t unpack(input logic [`PE_DATA_W-1:0] x);
    pe_pkg::pe_unpacked_t u;
    u.sign    = x[`PE_DATA_W-1];
    u.exp     = x[`PE_DATA_W-2 -: `PE_EXP_W];
    u.is_zero = (u.exp == '0); // subnormals read as zero
    // hidden bit only for normals, flushed fraction otherwise
    u.sig     = u.is_zero ? '0 : {1'b1, x[`PE_MAN_W-1:0]};
    return u;
  endfunction

  pe_pkg::pe_dec_t beat_d; // beat before the register

  always_comb begin
    beat_d.op = in_op; // op passes unchanged
    beat_d.a  = unpack(in_a);
    beat_d.b  = unpack(in_b);
  end

  ////////////////////////////////////////
  // stage 1 register
  ////////////////////////////////////////

  pe_pipe_reg #(
    .payload_t (pe_pkg::pe_dec_t)
  ) i_dec_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .up_valid (in_valid),
    .up_ready (in_ready),
    .up_data  (beat_d),
    .dn_valid (dec_valid),
    .dn_ready (dec_ready),
    .dn_data  (dec_beat)
  );

endmodule

// ==== hw/pe_pipe_reg.sv ====
`timescale 1ns/1ns
`include "pe_defs.svh"

// single-entry valid/ready stage
module pe_pipe_reg #(
  parameter type payload_t = logic [`PE_DATA_W-1:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     up_valid,
  output logic     up_ready,
  input  payload_t up_data,
  output logic     dn_valid,
  input  logic     dn_ready,
  output payload_t dn_data
);

  logic run; // comes up one edge after reset releases

  // accept when empty or when the held beat leaves this cycle
  assign up_ready = run && (!dn_valid || dn_ready);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run      <= 1'b0;
      dn_valid <= 1'b0;
    end else begin
      run <= 1'b1;
      if (up_ready) dn_valid <= up_valid; // refill or drain
    end
  end

  always_ff @(posedge clk) begin
    if (up_ready && up_valid) dn_data <= up_data; // payload only
  end

endmodule

// ==== hw/pe_pkg.sv ====
`include "pe_defs.svh"

package pe_pkg;

  ////////////////////////////////////////
  // operation codes
  ////////////////////////////////////////

  // bit 1 picks the multiplier, bit 0 picks subtract in the adder
  typedef enum logic [1:0] {
    OP_ADD     = 2'd0,
    OP_SUB     = 2'd1,
    OP_MUL     = 2'd2,
    OP_MUL_ALT = 2'd3  // bit 1 set, so this multiplies too
  } pe_op_e;

  ////////////////////////////////////////
  // decoded operands
  ////////////////////////////////////////

  typedef struct packed {
    logic                 sign;
    logic [`PE_EXP_W-1:0] exp;     // still biased
    logic [`PE_MAN_W:0]   sig;     // hidden bit on top
    logic                 is_zero; // zero or flushed subnormal
  } pe_unpacked_t;

  // one beat as seen by the arithmetic units
  typedef struct packed {
    pe_op_e       op;
    pe_unpacked_t a;
    pe_unpacked_t b;
  } pe_dec_t;

endpackage

// ==== hw/pe_result.sv ====
`timescale 1ns/1ns
`include "pe_defs.svh"

module pe_result (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  dec_valid,
  output logic                  dec_ready,
  input  pe_pkg::pe_op_e        op,
  input  logic [`PE_DATA_W-1:0] sum,
  input  logic [`PE_DATA_W-1:0] product,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [`PE_DATA_W-1:0] out_data
);

  logic [`PE_DATA_W-1:0] pick; // chosen unit result

  // op bit 1 means multiply, codes 2 and 3 alike
  assign pick = op[1] ? product : sum;

  ////////////////////////////////////////
  // stage 2 register
  ////////////////////////////////////////

  pe_pipe_reg #(
    .payload_t (logic [`PE_DATA_W-1:0])
  ) i_out_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .up_valid (dec_valid),
    .up_ready (dec_ready), // stall goes back to decode
    .up_data  (pick),
    .dn_valid (out_valid),
    .dn_ready (out_ready),
    .dn_data  (out_data)
  );

endmodule

// ==== hw/pe_top.sv ====
`timescale 1ns/1ns
`include "pe_defs.svh"

// processing element, decode -> {add/sub, mul} -> result
module pe_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [`PE_DATA_W-1:0] in_a,
  input  logic [`PE_DATA_W-1:0] in_b,
  input  pe_pkg::pe_op_e        in_op,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [`PE_DATA_W-1:0] out_data
);

  logic                  dec_valid;
  logic                  dec_ready;
  pe_pkg::pe_dec_t       dec_beat;
  logic [`PE_DATA_W-1:0] sum;
  logic [`PE_DATA_W-1:0] product;

  pe_decode i_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_a      (in_a),
    .in_b      (in_b),
    .in_op     (in_op),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_beat  (dec_beat)
  );

  // both units run on every beat, result stage picks one
  fp_add_sub i_add_sub (
    .beat (dec_beat),
    .sum  (sum)
  );

  fp_mul i_mul (
    .beat    (dec_beat),
    .product (product)
  );

  pe_result i_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .op        (dec_beat.op),
    .sum       (sum),
    .product   (product),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

// ==== include/pe_defs.svh ====
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

////////////////////////////////////////
// ieee-754 binary64 format
////////////////////////////////////////

// operand and result width
`define PE_DATA_W   64

// biased exponent field
`define PE_EXP_W    11

// stored fraction, hidden bit not counted
`define PE_MAN_W    52

// exponent bias of binary64
`define PE_EXP_BIAS 1023

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the processing element testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module pe_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep going past assertion errors so the testbench can give its verdict
sim_out=$(./obj_dir/Vpe_tb +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

// ==== testbench/pe_chk.sv ====
`timescale 1ns/1ns
`include "pe_defs.svh"

// handshake and reset checks on the pe streams
module pe_chk (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  in_ready,
  input logic                  out_valid,
  input logic                  out_ready,
  input logic [`PE_DATA_W-1:0] out_data
);

  int fail_cnt = 0; // failed assertions so far

  ////////////////////////////////////////
  // reset state
  ////////////////////////////////////////

  // one edge into reset, both sides quiet
  reset_quiet: assert property (@(posedge clk) !rst_n |=> (!out_valid && !in_ready))
    else begin
      $error("stream active right after a reset edge");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // output stall
  ////////////////////////////////////////

  stall_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> out_valid)
    else begin
      $error("out_valid dropped while the beat was stalled");
      fail_cnt++;
    end

  stall_data: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> $stable(out_data))
    else begin
      $error("out_data changed while the beat was stalled");
      fail_cnt++;
    end

endmodule

// ==== testbench/pe_scoreboard.sv ====
`timescale 1ns/1ns
`include "pe_defs.svh"

// watches both pe streams, compares against a real-number model
module pe_scoreboard (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  logic                  in_ready,
  input  logic [`PE_DATA_W-1:0] in_a,
  input  logic [`PE_DATA_W-1:0] in_b,
  input  pe_pkg::pe_op_e        in_op,
  input  logic                  out_valid,
  input  logic                  out_ready,
  input  logic [`PE_DATA_W-1:0] out_data,
  input  int                    test_num,
  input  logic                  test_end,
  input  logic                  final_chk,
  output int                    err_cnt,
  output int                    acc_cnt,
  output int                    emit_cnt,
  output int                    pending
);

  logic [`PE_DATA_W-1:0] exp_q[$]; // oldest first
  logic [`PE_DATA_W-1:0] exp_v;
  int                    test_err;
  int                    test_beats;

  // ieee result, then flush below 2^-1022 and +0 on cancellation
  function automatic logic [`PE_DATA_W-1:0] expected_result(
    input logic [`PE_DATA_W-1:0] a,
    input logic [`PE_DATA_W-1:0] b,
    input pe_pkg::pe_op_e        op
  );
    real  ra;
    real  rb;
    real  r;
    real  min_norm;
    logic sb; // b sign as seen by the adder
    logic sign;
    ra       = $bitstoreal(a);
    rb       = $bitstoreal(b);
    min_norm = $bitstoreal(64'h0010_0000_0000_0000);
    sb       = b[63] ^ (op == pe_pkg::OP_SUB);
    if (op[1]) begin
      r    = ra * rb;
      sign = a[63] ^ b[63];
    end else begin
      r    = (op == pe_pkg::OP_SUB) ? ra - rb : ra + rb;
      sign = (r < 0.0);
      if (r == 0.0) return {a[63] & sb & ~|a[62:0] & ~|b[62:0], 63'b0}; // -0 only from -0 + -0
    end
    if (r > -min_norm && r < min_norm) return {sign, 63'b0};
    return $realtobits(r); // overflow already signed infinity
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      err_cnt    = 0;
      acc_cnt    = 0;
      emit_cnt   = 0;
      test_err   = 0;
      test_beats = 0;
      exp_q.delete();
    end else begin
      if (in_valid && in_ready) begin
        exp_q.push_back(expected_result(in_a, in_b, in_op));
        acc_cnt++;
        test_beats++;
      end
      if (out_valid && out_ready) begin
        emit_cnt++;
        if (exp_q.size() == 0) begin
          $display("output beat at %0t with no expected value left", $time);
          err_cnt++;
          test_err++;
        end else begin
          exp_v = exp_q.pop_front();
          if (out_data !== exp_v) begin
            $display("FAIL %0t out_data expected %h got %h", $time, exp_v, out_data);
            err_cnt++;
            test_err++;
          end
        end
      end
      if (test_end) begin // one line per finished test
        $display("test %0d: %0d beats, %0d mismatches, %s", test_num, test_beats, test_err,
                 (test_err == 0) ? "ok" : "failed");
        test_err   = 0;
        test_beats = 0;
      end
      if (final_chk && exp_q.size() != 0) begin
        $display("%0d accepted beats never came out", exp_q.size());
        err_cnt++;
      end
      if (final_chk && acc_cnt != emit_cnt) begin
        $display("accepted count %0d differs from emitted count %0d", acc_cnt, emit_cnt);
        err_cnt++;
      end
    end
    pending = exp_q.size();
  end

endmodule

// ==== testbench/pe_tb.sv ====
`timescale 1ns/1ns
`include "pe_defs.svh"

module pe_tb;

  localparam int CLK_NS      = 8;
  localparam int RESET_CYC   = 16;
  localparam int TOTAL_BEATS = 940; // 200 + 200 + 200 + 40 + 300
  localparam int TIMEOUT_NS  = (TOTAL_BEATS * 20 + RESET_CYC) * CLK_NS;
  localparam int DRAIN_CYC   = 10;  // two stages empty well within this

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  logic                  in_ready;
  logic [`PE_DATA_W-1:0] in_a;
  logic [`PE_DATA_W-1:0] in_b;
  pe_pkg::pe_op_e        in_op;
  logic                  out_valid;
  logic                  out_ready;
  logic [`PE_DATA_W-1:0] out_data;
  int                    test_num;
  logic                  test_end;
  logic                  final_chk;
  int                    err_cnt;
  int                    acc_cnt;
  int                    emit_cnt;
  int                    pending;
  logic                  bp_on; // random out_ready while set
  logic [31:0]           rng;

  pe_top i_dut (.*);
  pe_scoreboard i_sb (.*);
  bind pe_top pe_chk i_chk (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin // watchdog
    #(TIMEOUT_NS);
    $display("timeout: the run did not complete in %0d ns", TIMEOUT_NS);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////
  // random numbers
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic real pow2(input int e);
    return $bitstoreal({1'b0, 11'(e + `PE_EXP_BIAS), {`PE_MAN_W{1'b0}}});
  endfunction

  // k * 2^e, |k| <= 1023, so sums and products stay exact
  function automatic logic [63:0] rand_operand(input int e_lo, input int e_hi);
    logic [31:0] r_k;
    logic [31:0] r_e;
    int          k;
    int          e;
    r_k = next_rand();
    r_e = next_rand();
    k   = int'(r_k % 32'd2047) - 1023;
    e   = e_lo + int'(r_e % 32'(e_hi - e_lo + 1));
    return $realtobits(real'(k) * pow2(e));
  endfunction

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic step();
    logic [31:0] r;
    @(posedge clk);
    #1;
    if (bp_on) begin
      r         = next_rand();
      out_ready = r[0];
    end
  endtask

  task automatic send_beat(input logic [63:0] a, input logic [63:0] b, input pe_pkg::pe_op_e op);
    logic done;
    in_valid = 1'b1;
    in_a     = a;
    in_b     = b;
    in_op    = op;
    done     = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = in_ready; // same value the DUT saw at this edge
      #1;
      if (bp_on) begin
        rng       = next_rand();
        out_ready = rng[0];
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic finish_test(input int num);
    int n;
    bp_on     = 1'b0;
    out_ready = 1'b1;
    n         = 0;
    while (pending != 0 && n < DRAIN_CYC) begin // beats still in flight
      step();
      n++;
    end
    test_num = num;
    test_end = 1'b1;
    step();
    test_end = 1'b0;
  endtask

  task automatic random_ops(input int num, input int beats, input int mode);
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] r;
    pe_pkg::pe_op_e op;
    repeat (beats) begin
      a  = rand_operand(-8, 8);
      b  = rand_operand(-8, 8);
      r  = next_rand();
      op = pe_pkg::pe_op_e'(mode);
      if (mode == 1 && r[2:0] == 3'd0) b = a; // exact cancellation
      if (mode == 2) op = r[3] ? pe_pkg::OP_MUL_ALT : pe_pkg::OP_MUL;
      if (mode == 2 && r[2:0] == 3'd0) a = {r[4], 63'b0}; // signed zero operand
      if (mode == 3) begin // mixed ops with gaps
        op = pe_pkg::pe_op_e'(r[3:2]);
        repeat (int'(r[1:0])) step();
      end
      send_beat(a, b, op);
    end
    finish_test(num);
  endtask

  task automatic limit_muls();
    repeat (20) send_beat(rand_operand(990, 1000), rand_operand(990, 1000), pe_pkg::OP_MUL);
    repeat (20) send_beat(rand_operand(-1000, -990), rand_operand(-1000, -990), pe_pkg::OP_MUL);
    finish_test(4);
  endtask

  initial begin
    rng       = 32'd10;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_a      = '0;
    in_b      = '0;
    in_op     = pe_pkg::OP_ADD;
    out_ready = 1'b1;
    test_num  = 0;
    test_end  = 1'b0;
    final_chk = 1'b0;
    bp_on     = 1'b0;
    repeat (RESET_CYC) @(posedge clk);
    #1;
    rst_n = 1'b1;
    random_ops(1, 200, 0);
    random_ops(2, 200, 1);
    random_ops(3, 200, 2);
    limit_muls();
    bp_on = 1'b1;
    random_ops(5, 300, 3);
    final_chk = 1'b1;
    step();
    final_chk = 1'b0;
    $display("accepted %0d, emitted %0d, errors %0d, assertion failures %0d",
             acc_cnt, emit_cnt, err_cnt, i_dut.i_chk.fail_cnt);
    if (err_cnt == 0 && i_dut.i_chk.fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
